//--- Bender.yml
package:
  name: scurve_scan

sources:
  - files:
      - scurve_pkg.sv
      - scurve_apb_pkg.sv
      - scurve_data_fifo.sv
      - scurve_scan_ctrl.sv
      - scurve_apb_regs.sv
      - scurve_top.sv
  - target: test
    files:
      - scurve_properties.sv
      - tb_scurve.sv

//--- scurve_apb_pkg.sv
`default_nettype none

package scurve_apb_pkg;

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // Register map.
  localparam apb_addr_t ADDR_CTRL   = 8'h00;
  localparam apb_addr_t ADDR_RANGE  = 8'h04;
  localparam apb_addr_t ADDR_WINDOW = 8'h08;
  localparam apb_addr_t ADDR_STATUS = 8'h0c;
  localparam apb_addr_t ADDR_DATA   = 8'h10;

  localparam int CTRL_START_BIT   = 0;   // Write one to start a scan.
  localparam int RANGE_START_LSB  = 0;
  localparam int RANGE_STOP_LSB   = 8;
  localparam int RANGE_STEP_LSB   = 16;
  localparam int WINDOW_LEN_LSB   = 0;
  localparam int STATUS_BUSY_BIT  = 0;
  localparam int STATUS_EMPTY_BIT = 1;
  localparam int STATUS_FULL_BIT  = 2;
  localparam int STATUS_LEVEL_LSB = 4;   // Level sits in bits 8:4.
  localparam int DATA_WORD_LSB    = 0;

endpackage

`default_nettype wire

//--- scurve_apb_regs.sv
`default_nettype none

module scurve_apb_regs (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire scurve_apb_pkg::apb_addr_t paddr,
  input  wire scurve_apb_pkg::apb_data_t pwdata,
  input  wire logic                      busy,
  input  wire logic                      fifo_empty,
  input  wire logic                      fifo_full,
  input  wire scurve_pkg::fifo_level_t   fifo_level,
  input  wire scurve_pkg::fifo_word_t    head_word,
  output scurve_apb_pkg::apb_data_t      prdata,
  output logic                           pslverr,
  output logic                           start,
  output scurve_pkg::dac_t               dac_start,
  output scurve_pkg::dac_t               dac_stop,
  output scurve_pkg::dac_t               dac_step,
  output scurve_pkg::window_t            window_len,
  output logic                           pop
);

  logic                      rd_acc;
  logic                      wr_acc;
  logic                      mapped;
  logic                      data_rd;
  scurve_apb_pkg::apb_data_t cfg_rdata;   // Captured in the setup cycle.
  scurve_apb_pkg::apb_data_t status_word;

  assign rd_acc  = psel && penable && !pwrite;
  assign wr_acc  = psel && penable && pwrite;
  assign data_rd = rd_acc && (paddr == scurve_apb_pkg::ADDR_DATA);
  assign pop     = data_rd && !fifo_empty;

  always_comb begin
    case (paddr)
      scurve_apb_pkg::ADDR_CTRL,
      scurve_apb_pkg::ADDR_RANGE,
      scurve_apb_pkg::ADDR_WINDOW,
      scurve_apb_pkg::ADDR_STATUS,
      scurve_apb_pkg::ADDR_DATA: mapped = 1'b1;
      default:                   mapped = 1'b0;
    endcase
  end

  assign pslverr = psel && penable && (!mapped || (data_rd && fifo_empty));

  always_comb begin
    status_word = '0;
    status_word[scurve_apb_pkg::STATUS_BUSY_BIT]  = busy;
    status_word[scurve_apb_pkg::STATUS_EMPTY_BIT] = fifo_empty;
    status_word[scurve_apb_pkg::STATUS_FULL_BIT]  = fifo_full;
    status_word[scurve_apb_pkg::STATUS_LEVEL_LSB +: $bits(scurve_pkg::fifo_level_t)] = fifo_level;
  end

  always_comb begin
    prdata = '0;
    if (rd_acc) begin
      case (paddr)
        scurve_apb_pkg::ADDR_RANGE,
        scurve_apb_pkg::ADDR_WINDOW: prdata = cfg_rdata;
        scurve_apb_pkg::ADDR_STATUS: prdata = status_word;
        scurve_apb_pkg::ADDR_DATA: begin
          if (!fifo_empty) begin  // Empty read returns zero.
            prdata[scurve_apb_pkg::DATA_WORD_LSB +: $bits(scurve_pkg::fifo_word_t)] = head_word;
          end
        end
        default: prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start      <= 1'b0;
      dac_start  <= '0;
      dac_stop   <= '0;
      dac_step   <= '0;
      window_len <= '0;
      cfg_rdata  <= '0;
    end else begin
      start <= wr_acc && (paddr == scurve_apb_pkg::ADDR_CTRL)
               && pwdata[scurve_apb_pkg::CTRL_START_BIT];
      if (wr_acc && (paddr == scurve_apb_pkg::ADDR_RANGE)) begin
        dac_start <= pwdata[scurve_apb_pkg::RANGE_START_LSB +: $bits(scurve_pkg::dac_t)];
        dac_stop  <= pwdata[scurve_apb_pkg::RANGE_STOP_LSB +: $bits(scurve_pkg::dac_t)];
        dac_step  <= pwdata[scurve_apb_pkg::RANGE_STEP_LSB +: $bits(scurve_pkg::dac_t)];
      end
      if (wr_acc && (paddr == scurve_apb_pkg::ADDR_WINDOW)) begin
        window_len <= pwdata[scurve_apb_pkg::WINDOW_LEN_LSB +: $bits(scurve_pkg::window_t)];
      end
      // Config readback is staged during the setup cycle.
      if (psel && !penable && !pwrite) begin
        cfg_rdata <= '0;
        if (paddr == scurve_apb_pkg::ADDR_RANGE) begin
          cfg_rdata[scurve_apb_pkg::RANGE_START_LSB +: $bits(scurve_pkg::dac_t)] <= dac_start;
          cfg_rdata[scurve_apb_pkg::RANGE_STOP_LSB +: $bits(scurve_pkg::dac_t)]  <= dac_stop;
          cfg_rdata[scurve_apb_pkg::RANGE_STEP_LSB +: $bits(scurve_pkg::dac_t)]  <= dac_step;
        end else if (paddr == scurve_apb_pkg::ADDR_WINDOW) begin
          cfg_rdata[scurve_apb_pkg::WINDOW_LEN_LSB +: $bits(scurve_pkg::window_t)] <= window_len;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- scurve_data_fifo.sv
`default_nettype none

module scurve_data_fifo (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire scurve_pkg::fifo_word_t   din,
  input  wire logic                     wr_en,
  input  wire logic                     rd_en,
  output scurve_pkg::fifo_word_t        dout,
  output logic                          full,
  output logic                          empty,
  output scurve_pkg::fifo_level_t       level
);

  scurve_pkg::fifo_word_t mem [scurve_pkg::FIFO_DEPTH];

  logic [scurve_pkg::FIFO_ADDR_W-1:0] wr_ptr;
  logic [scurve_pkg::FIFO_ADDR_W-1:0] rd_ptr;
  logic                               do_wr;
  logic                               do_rd;

  assign full  = (level == scurve_pkg::fifo_level_t'(scurve_pkg::FIFO_DEPTH));
  assign empty = (level == '0);

  // Overflow and underflow requests are dropped.
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign dout = mem[rd_ptr];  // Head word, first-word-fall-through.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at the depth.
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= '0;
    end else if (do_wr && !do_rd) begin
      level <= level + 1'b1;
    end else if (do_rd && !do_wr) begin
      level <= level - 1'b1;
    end
  end

  // Storage comes up cleared.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < scurve_pkg::FIFO_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

`default_nettype wire

//--- scurve_pkg.sv
`default_nettype none

package scurve_pkg;

  // Scan data widths.
  typedef logic [7:0]  dac_t;        // Threshold DAC code.
  typedef logic [7:0]  hit_count_t;  // Hits counted in one window.
  typedef logic [15:0] window_t;     // Window length in clock cycles.

  // Result word. Upper byte is the DAC code, lower byte the hit count.
  typedef logic [15:0] fifo_word_t;

  localparam hit_count_t HIT_MAX = 8'hff;  // Saturation value.

  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_ADDR_W = 4;

  typedef logic [FIFO_ADDR_W:0] fifo_level_t;  // 0 to FIFO_DEPTH.

  typedef enum logic [1:0] {
    SCAN_IDLE,
    SCAN_COUNT,
    SCAN_PUSH,
    SCAN_NEXT
  } scan_state_t;

endpackage

`default_nettype wire

//--- scurve_properties.sv
`default_nettype none

module scurve_properties (
  input wire logic                    clk,
  input wire logic                    rst_n,
  input wire logic                    psel,
  input wire logic                    penable,
  input wire logic                    pslverr,
  input wire logic                    push,
  input wire logic                    full,
  input wire logic                    busy,
  input wire logic                    window_open,
  input wire scurve_pkg::fifo_level_t level
);
  timeunit 1ns;
  timeprecision 1ps;

  push_not_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("push raised while the FIFO is full");

  window_in_scan: assert property (@(posedge clk) disable iff (!rst_n) window_open |-> busy)
    else $error("window open outside a scan");

  // Error response belongs to the access cycle only.
  slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
                                     pslverr |-> (psel && penable))
    else $error("pslverr outside an access cycle");

  level_in_range: assert property (@(posedge clk) disable iff (!rst_n)
                                   level <= scurve_pkg::fifo_level_t'(scurve_pkg::FIFO_DEPTH))
    else $error("FIFO level above its depth");

endmodule

bind scurve_top scurve_properties u_scurve_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .psel        (psel),
  .penable     (penable),
  .pslverr     (pslverr),
  .push        (push),
  .full        (full),
  .busy        (busy),
  .window_open (window_open),
  .level       (level)
);

`default_nettype wire

//--- scurve_scan_ctrl.sv
`default_nettype none

module scurve_scan_ctrl (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   start,
  input  wire scurve_pkg::dac_t       dac_start,
  input  wire scurve_pkg::dac_t       dac_stop,
  input  wire scurve_pkg::dac_t       dac_step,
  input  wire scurve_pkg::window_t    window_len,
  input  wire logic                   hit,
  input  wire logic                   fifo_full,
  output logic                        busy,
  output scurve_pkg::dac_t            dac_code,
  output logic                        window_open,
  output logic                        push,
  output scurve_pkg::fifo_word_t      push_word
);

  scurve_pkg::scan_state_t state;

  // Configuration captured at start.
  scurve_pkg::dac_t    cfg_stop;
  scurve_pkg::dac_t    cfg_step;
  scurve_pkg::window_t cfg_window;

  scurve_pkg::window_t    win_cnt;   // Cycles left in the open window.
  scurve_pkg::hit_count_t hit_cnt;

  logic [8:0] next_code;  // One extra bit to see a pass beyond 255.
  logic       last_point;

  assign busy        = (state != scurve_pkg::SCAN_IDLE);
  assign window_open = (state == scurve_pkg::SCAN_COUNT);
  assign push        = (state == scurve_pkg::SCAN_PUSH) && !fifo_full;
  assign push_word   = {dac_code, hit_cnt};

  assign next_code = {1'b0, dac_code} + {1'b0, cfg_step};

  // A carry into bit 8 always lands above any stop code.
  assign last_point = (next_code > {1'b0, cfg_stop});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= scurve_pkg::SCAN_IDLE;
      dac_code <= '0;
      win_cnt  <= '0;
    end else begin
      case (state)
        scurve_pkg::SCAN_IDLE: begin
          if (start) begin  // Start pulses during a scan are not seen here.
            dac_code <= dac_start;
            state    <= scurve_pkg::SCAN_NEXT;
          end
        end

        // Code settles for one cycle before the window opens.
        scurve_pkg::SCAN_NEXT: begin
          win_cnt <= cfg_window;
          state   <= scurve_pkg::SCAN_COUNT;
        end

        scurve_pkg::SCAN_COUNT: begin
          if (win_cnt <= scurve_pkg::window_t'(1)) begin
            state <= scurve_pkg::SCAN_PUSH;
          end else begin
            win_cnt <= win_cnt - 1'b1;
          end
        end

        scurve_pkg::SCAN_PUSH: begin
          if (!fifo_full) begin  // Wait here while the FIFO is full.
            if (last_point) begin
              state <= scurve_pkg::SCAN_IDLE;
            end else begin
              dac_code <= next_code[7:0];
              state    <= scurve_pkg::SCAN_NEXT;
            end
          end
        end

        default: begin
          state <= scurve_pkg::SCAN_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == scurve_pkg::SCAN_IDLE) && start) begin
      cfg_stop   <= dac_stop;
      cfg_step   <= (dac_step == '0) ? scurve_pkg::dac_t'(1) : dac_step;
      cfg_window <= (window_len == '0) ? scurve_pkg::window_t'(1) : window_len;
    end
  end

  // Saturating hit counter, cleared before each window.
  always_ff @(posedge clk) begin
    if (state == scurve_pkg::SCAN_NEXT) begin
      hit_cnt <= '0;
    end else if (window_open && hit && (hit_cnt != scurve_pkg::HIT_MAX)) begin
      hit_cnt <= hit_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- scurve_top.sv
`default_nettype none

module scurve_top (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire scurve_apb_pkg::apb_addr_t paddr,
  input  wire scurve_apb_pkg::apb_data_t pwdata,
  output scurve_apb_pkg::apb_data_t      prdata,
  output logic                           pslverr,
  input  wire logic                      hit,
  output scurve_pkg::dac_t               dac_code,
  output logic                           window_open
);

  // Register file to scan controller.
  logic                   start;
  logic                   busy;
  scurve_pkg::dac_t       dac_start;
  scurve_pkg::dac_t       dac_stop;
  scurve_pkg::dac_t       dac_step;
  scurve_pkg::window_t    window_len;

  // FIFO side.
  logic                   push;
  logic                   pop;
  logic                   full;
  logic                   empty;
  scurve_pkg::fifo_word_t push_word;
  scurve_pkg::fifo_word_t head_word;
  scurve_pkg::fifo_level_t level;

  scurve_apb_regs u_apb_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .busy       (busy),
    .fifo_empty (empty),
    .fifo_full  (full),
    .fifo_level (level),
    .head_word  (head_word),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .start      (start),
    .dac_start  (dac_start),
    .dac_stop   (dac_stop),
    .dac_step   (dac_step),
    .window_len (window_len),
    .pop        (pop)
  );

  scurve_scan_ctrl u_scan_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .dac_start   (dac_start),
    .dac_stop    (dac_stop),
    .dac_step    (dac_step),
    .window_len  (window_len),
    .hit         (hit),
    .fifo_full   (full),
    .busy        (busy),
    .dac_code    (dac_code),
    .window_open (window_open),
    .push        (push),
    .push_word   (push_word)
  );

  scurve_data_fifo u_data_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (push_word),
    .wr_en (push),
    .rd_en (pop),
    .dout  (head_word),
    .full  (full),
    .empty (empty),
    .level (level)
  );

endmodule

`default_nettype wire

//--- scurve_vectors.txt
// Hex columns: start stop step window_len threshold (step and window of 0 act as 1).
// A scan of more than 16 points runs into a full FIFO before it is drained.
10 20 04 0010 18
00 07 00 0003 04
40 30 08 0005 00
f0 ff 07 0004 f7
20 28 02 0000 24
80 80 01 0120 ff
00 2f 02 0003 10
05 50 10 000c 35

//--- sources.f
scurve_pkg.sv
scurve_apb_pkg.sv
scurve_data_fifo.sv
scurve_scan_ctrl.sv
scurve_apb_regs.sv
scurve_top.sv
scurve_properties.sv
tb_scurve.sv

//--- tb_scurve.sv
`default_nettype none

module tb_scurve;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 20000;  // Polls or reads before a wait gives up.

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  scurve_apb_pkg::apb_addr_t paddr;
  scurve_apb_pkg::apb_data_t pwdata;
  scurve_apb_pkg::apb_data_t prdata;
  logic                      pslverr;
  logic                      hit;
  scurve_pkg::dac_t          dac_code;
  logic                      window_open;

  logic [15:0]            vec_mem [0:79];  // Five columns per scan setup.
  scurve_pkg::fifo_word_t exp_q [$];       // Words built by the window monitor.
  logic [31:0]            rng;
  scurve_pkg::dac_t       thr;             // Discriminator threshold code.
  int                     exp_window;
  logic                   in_window;
  int                     burst_len;
  scurve_pkg::hit_count_t burst_hits;
  scurve_pkg::dac_t       burst_code;

  scurve_top u_scurve_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .hit         (hit),
    .dac_code    (dac_code),
    .window_open (window_open)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic fail_with(input string what);
    $display("Error: %s", what);
    stop_run();
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic apb_access(input logic wr, input scurve_apb_pkg::apb_addr_t addr,
                            input scurve_apb_pkg::apb_data_t wdata,
                            output scurve_apb_pkg::apb_data_t rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;  // Mid access cycle, before the completing edge.
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input scurve_apb_pkg::apb_addr_t addr,
                           input scurve_apb_pkg::apb_data_t wdata);
    scurve_apb_pkg::apb_data_t rd;
    logic err;
    apb_access(1'b1, addr, wdata, rd, err);
    check_equal("write pslverr", 1'b0, err);
  endtask

  task automatic wait_status(input int bit_pos, input logic value, input string what);
    scurve_apb_pkg::apb_data_t st;
    logic err;
    int polls;
    polls = 0;
    apb_access(1'b0, scurve_apb_pkg::ADDR_STATUS, '0, st, err);
    while (st[bit_pos] !== value) begin
      polls++;
      if (polls > WAIT_LIMIT) fail_with({"status never showed ", what});
      apb_access(1'b0, scurve_apb_pkg::ADDR_STATUS, '0, st, err);
    end
  endtask

  // Reads result words until the whole scan has arrived.
  task automatic drain_words(input int npoints, input scurve_pkg::dac_t first,
                             input scurve_pkg::dac_t step);
    scurve_apb_pkg::apb_data_t rd;
    logic err;
    int got;
    int idle;
    scurve_pkg::dac_t code;
    got  = 0;
    idle = 0;
    code = first;
    while (got < npoints) begin
      apb_access(1'b0, scurve_apb_pkg::ADDR_DATA, '0, rd, err);
      if (err) begin
        check_equal("empty data read value", '0, rd);
        idle++;
        if (idle > WAIT_LIMIT) fail_with("result words stopped arriving");
      end else begin
        if (exp_q.size() == 0) fail_with("a word was read before its window closed");
        check_equal("dac code", code, rd[15:8]);
        check_equal("result word", exp_q.pop_front(), rd[15:0]);
        check_equal("data upper bits", '0, rd[31:16]);
        code = code + step;
        got++;
      end
    end
  endtask

  task automatic run_scan(input int idx);
    scurve_apb_pkg::apb_data_t rd;
    logic err;
    int npoints;
    scurve_pkg::dac_t first;
    scurve_pkg::dac_t last;
    scurve_pkg::dac_t step;
    scurve_pkg::dac_t held;
    first      = vec_mem[idx*5][7:0];
    last       = vec_mem[idx*5+1][7:0];
    step       = (vec_mem[idx*5+2][7:0] == 8'h00) ? 8'h01 : vec_mem[idx*5+2][7:0];
    exp_window = (vec_mem[idx*5+3] == 16'h0000) ? 1 : vec_mem[idx*5+3];
    thr        = vec_mem[idx*5+4][7:0];
    npoints    = (last < first) ? 1 : (last - first) / step + 1;
    apb_write(scurve_apb_pkg::ADDR_RANGE, {8'h00, vec_mem[idx*5+2][7:0], last, first});
    apb_write(scurve_apb_pkg::ADDR_WINDOW, {16'h0000, vec_mem[idx*5+3]});
    apb_write(scurve_apb_pkg::ADDR_CTRL, 32'h1);
    wait_status(scurve_apb_pkg::STATUS_BUSY_BIT, 1'b1, "busy after start");
    if (npoints > scurve_pkg::FIFO_DEPTH) begin
      wait_status(scurve_apb_pkg::STATUS_FULL_BIT, 1'b1, "a full FIFO");
      held = dac_code;
      apb_access(1'b0, scurve_apb_pkg::ADDR_STATUS, '0, rd, err);
      check_equal("busy while full", 1'b1, rd[scurve_apb_pkg::STATUS_BUSY_BIT]);
      check_equal("level while full", 16, rd[8:4]);
      apb_write(scurve_apb_pkg::ADDR_CTRL, 32'h1);  // Ignored, scan still running.
      check_equal("dac code held while full", held, dac_code);
    end else begin
      wait_status(scurve_apb_pkg::STATUS_BUSY_BIT, 1'b0, "the scan ending");
    end
    drain_words(npoints, first, step);
    wait_status(scurve_apb_pkg::STATUS_BUSY_BIT, 1'b0, "the scan ending");
    apb_access(1'b0, scurve_apb_pkg::ADDR_DATA, '0, rd, err);
    check_equal("extra word pslverr", 1'b1, err);
    check_equal("extra word value", '0, rd);
    apb_access(1'b0, scurve_apb_pkg::ADDR_STATUS, '0, rd, err);
    check_equal("status after drain", 32'h2, rd);
    check_equal("unread model words", 0, exp_q.size());
  endtask

  // Discriminator model and window monitor, both on the falling edge.
  always @(negedge clk) begin
    rng = xorshift32(rng);
    if (dac_code < thr) begin
      hit = 1'b1;
    end else if (dac_code > thr) begin
      hit = 1'b0;
    end else begin
      hit = rng[0];  // Noisy right at the threshold.
    end
    if (window_open) begin
      if (!in_window) begin
        in_window  = 1'b1;
        burst_len  = 0;
        burst_hits = '0;
        burst_code = dac_code;
      end
      burst_len++;
      if (hit && (burst_hits != 8'hff)) burst_hits++;
      check_equal("dac code in window", burst_code, dac_code);
    end else if (in_window) begin
      in_window = 1'b0;
      check_equal("window length", exp_window, burst_len);
      exp_q.push_back({burst_code, burst_hits});
    end
  end

  initial begin
    scurve_apb_pkg::apb_data_t rd;
    logic err;
    int nvec;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    hit        = 1'b0;
    rng        = 32'h9f0c91e0;
    thr        = '0;
    exp_window = 1;
    in_window  = 1'b0;
    $readmemh("scurve_vectors.txt", vec_mem);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    apb_access(1'b0, scurve_apb_pkg::ADDR_STATUS, '0, rd, err);
    check_equal("status after reset", 32'h2, rd);
    apb_write(scurve_apb_pkg::ADDR_RANGE, 32'h12ab_cd34);
    apb_access(1'b0, scurve_apb_pkg::ADDR_RANGE, '0, rd, err);
    check_equal("range readback", 32'h00ab_cd34, rd);
    apb_write(scurve_apb_pkg::ADDR_WINDOW, 32'hdead_0042);
    apb_access(1'b0, scurve_apb_pkg::ADDR_WINDOW, '0, rd, err);
    check_equal("window readback", 32'h0000_0042, rd);
    apb_access(1'b0, 8'h14, '0, rd, err);
    check_equal("unmapped pslverr", 1'b1, err);
    apb_access(1'b0, scurve_apb_pkg::ADDR_DATA, '0, rd, err);
    check_equal("empty read pslverr", 1'b1, err);
    check_equal("empty read value", '0, rd);

    nvec = 0;
    while ((nvec < 16) && !$isunknown(vec_mem[nvec*5])) nvec++;
    if (nvec == 0) fail_with("the vectors file holds no scan setups");
    for (int i = 0; i < nvec; i++) begin
      run_scan(i);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
